// File: Makefile
VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= rv_core.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Simulation passed

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: rv_alu.sv
`timescale 1ns/1ns

module rv_alu (
	input  rv_exec_pkg::alu_op_t                   alu_op_i,
	input  logic [rv_exec_pkg::reg_data_width-1:0] s1_i,
	input  logic [rv_exec_pkg::reg_data_width-1:0] s2_i,
	output logic [rv_exec_pkg::reg_data_width-1:0] d_o,
	output logic                                   zero_o
);

	localparam int w = rv_exec_pkg::reg_data_width;

	always_comb begin
		case (alu_op_i)
			rv_exec_pkg::alu_add:    d_o = s1_i + s2_i;
			rv_exec_pkg::alu_sub:    d_o = s1_i - s2_i;
			rv_exec_pkg::alu_and:    d_o = s1_i & s2_i;
			rv_exec_pkg::alu_or:     d_o = s1_i | s2_i;
			rv_exec_pkg::alu_xor:    d_o = s1_i ^ s2_i;
			rv_exec_pkg::alu_slt:    d_o = {{(w - 1){1'b0}}, $signed(s1_i) < $signed(s2_i)};
			rv_exec_pkg::alu_sll:    d_o = s1_i << s2_i[4:0]; // shamt is low five bits
			rv_exec_pkg::alu_srl:    d_o = s1_i >> s2_i[4:0];
			rv_exec_pkg::alu_pass_b: d_o = s2_i;
			default:                 d_o = '0;
		endcase
	end

	// beq/bne look at this after a sub
	assign zero_o = (d_o == '0);

endmodule

// File: rv_br.sv
`timescale 1ns/1ns

module rv_br (
	input  rv_exec_pkg::br_op_t                    br_op_i,
	input  rv_exec_pkg::data_origin_t              origin_i,
	input  logic                                   zero_i,
	input  logic [rv_exec_pkg::reg_data_width-1:0] pc_i,
	input  logic [rv_exec_pkg::reg_data_width-1:0] s1_i,
	input  logic [rv_exec_pkg::reg_data_width-1:0] s2_i,
	output logic                                   taken_o,
	output logic [rv_exec_pkg::reg_data_width-1:0] target_o
);

	logic [rv_exec_pkg::reg_data_width-1:0] abs_sum;

	always_comb begin
		case (br_op_i)
			rv_exec_pkg::br_beq:  taken_o = zero_i;
			rv_exec_pkg::br_bne:  taken_o = !zero_i;
			rv_exec_pkg::br_jump: taken_o = 1'b1;
			default:              taken_o = 1'b0;
		endcase
	end

	// jalr is absolute, the rest are pc relative
	assign abs_sum = s1_i + s2_i;
	assign target_o = (origin_i == rv_exec_pkg::origin_rs2imm_rs1) ?
		{abs_sum[rv_exec_pkg::reg_data_width-1:1], 1'b0} : pc_i + s2_i;

endmodule

// File: rv_core.f
rv_exec_pkg.sv
rv_regfile.sv
rv_decode.sv
rv_alu.sv
rv_lis.sv
rv_br.sv
rv_data_mem.sv
rv_execution_unit.sv
rv_core_top.sv
rv_core_checker.sv
rv_core_tb.sv

// File: rv_core_checker.sv
`timescale 1ns/1ns

module rv_core_checker (
	input logic        clk_i,
	input logic        reset_i,
	input logic        instr_valid_i,
	input logic [31:0] instr_i,
	input logic        wb_valid_i,
	input logic [4:0]  wb_rd_i,
	input logic        redirect_i
);

	int fail_count = 0;
	logic issue_writes;

	// rv32i subset that ends in a register write
	function automatic logic writes_register(input logic [31:0] ins);
		logic [2:0] f3;
		f3 = ins[14:12];
		if (ins[11:7] == 5'd0) return 1'b0;
		case (ins[6:0])
			7'b0110011: return f3 != 3'b011; // no sltu
			7'b0010011: return f3 == 3'b000; // addi
			7'b0000011: return f3 == 3'b000 || f3 == 3'b010 || f3 == 3'b100;
			7'b0110111, 7'b0010111, 7'b1101111, 7'b1100111: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	assign issue_writes = instr_valid_i && writes_register(instr_i);

	// one full cycle of reset clears both strobes
	idle_in_reset: assert property (@(posedge clk_i)
		reset_i && $past(reset_i) |-> !wb_valid_i && !redirect_i)
		else begin
			$error("writeback or redirect strobe high during reset");
			fail_count++;
		end

	no_x0_writeback: assert property (@(posedge clk_i) disable iff (reset_i)
		wb_valid_i |-> wb_rd_i != 5'd0)
		else begin
			$error("writeback reported for x0");
			fail_count++;
		end

	// back-to-back redirects need back-to-back issues
	redirect_spacing: assert property (@(posedge clk_i) disable iff (reset_i)
		redirect_i && $past(redirect_i) |-> $past(instr_valid_i, 2) && $past(instr_valid_i, 3))
		else begin
			$error("consecutive redirects without consecutive issues");
			fail_count++;
		end

	// issue edge, execute edge, then the strobe
	wb_latency: assert property (@(posedge clk_i) disable iff (reset_i)
		wb_valid_i == $past(issue_writes, 2))
		else begin
			$error("writeback strobe not two edges after a writing issue");
			fail_count++;
		end

endmodule

bind rv_core_top rv_core_checker chk (
	.clk_i         (clk_i),
	.reset_i       (reset_i),
	.instr_valid_i (instr_valid_i),
	.instr_i       (instr_i),
	.wb_valid_i    (wb_valid_o),
	.wb_rd_i       (wb_rd_o),
	.redirect_i    (redirect_o)
);

// File: rv_core_tb.sv
`timescale 1ns/1ns

module rv_core_tb;

	localparam int dmem_addr_bits = 6;
	localparam int dmem_bytes = 4 * (2 ** dmem_addr_bits);

	localparam logic [6:0] op_reg    = 7'b0110011;
	localparam logic [6:0] op_imm    = 7'b0010011;
	localparam logic [6:0] op_load   = 7'b0000011;
	localparam logic [6:0] op_store  = 7'b0100011;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_jal    = 7'b1101111;
	localparam logic [6:0] op_jalr   = 7'b1100111;
	localparam logic [6:0] op_lui    = 7'b0110111;
	localparam logic [6:0] op_auipc  = 7'b0010111;

	localparam int n_seed = 62; // lui + addi for x1..x31
	localparam int n_alu = 200;
	localparam int n_chains = 20;
	localparam int chain_len = 8;
	localparam int n_mem = 40; // four instructions each
	localparam int n_br = 40; // three instructions each
	localparam int n_jmp = 40;
	localparam int n_post = 40;
	localparam int total_instrs = n_seed + n_alu + n_chains * chain_len + 4 * n_mem
		+ 3 * n_br + n_jmp + n_post;
	localparam int watchdog_ns = total_instrs * 4 + 2000;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic instr_valid = 1'b0;
	logic [31:0] instr = '0;
	logic [31:0] pc = '0;
	logic wb_valid;
	logic [4:0] wb_rd;
	logic [31:0] wb_data;
	logic redirect;
	logic [31:0] redirect_pc;

	logic [31:0] ref_regs [32];
	logic [7:0] ref_mem [dmem_bytes];
	logic [4:0] wb_rd_q [$];
	logic [31:0] wb_data_q [$];
	string wb_test_q [$];
	logic [31:0] redir_q [$];
	string redir_test_q [$];

	logic [31:0] lcg_state = 32'h69e9;
	logic [31:0] pc_cur = 32'h0000_1000;
	string test_name = "reset";
	int mismatches = 0;
	int other_errors = 0;
	int issued = 0;

	always #2 clk = ~clk;

	rv_core_top #(
		.DMEM_ADDR_BITS (dmem_addr_bits)
	) dut (
		.clk_i         (clk),
		.reset_i       (reset),
		.instr_valid_i (instr_valid),
		.instr_i       (instr),
		.pc_i          (pc),
		.wb_valid_o    (wb_valid),
		.wb_rd_o       (wb_rd),
		.wb_data_o     (wb_data),
		.redirect_o    (redirect),
		.redirect_pc_o (redirect_pc)
	);

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [4:0] rand_reg();
		logic [31:0] r;
		r = lcg_next();
		return r[31:27];
	endfunction

	function automatic logic [4:0] rand_reg_nz();
		logic [31:0] r;
		r = lcg_next();
		return 5'(r[31:16] % 31 + 1); // x1..x31
	endfunction

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, op_reg};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
	endfunction

	function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
	endfunction

	// regs_only keeps to the eight register-register ops
	function automatic logic [31:0] random_alu_instr(input logic [4:0] rd,
		input logic [4:0] rs1, input logic [4:0] rs2, input logic regs_only);
		logic [31:0] r;
		r = lcg_next();
		case (r[31:16] % (regs_only ? 8 : 11))
			0: return enc_r(7'h00, rs2, rs1, 3'b000, rd);
			1: return enc_r(7'h20, rs2, rs1, 3'b000, rd);
			2: return enc_r(7'h00, rs2, rs1, 3'b111, rd);
			3: return enc_r(7'h00, rs2, rs1, 3'b110, rd);
			4: return enc_r(7'h00, rs2, rs1, 3'b100, rd);
			5: return enc_r(7'h00, rs2, rs1, 3'b010, rd);
			6: return enc_r(7'h00, rs2, rs1, 3'b001, rd);
			7: return enc_r(7'h00, rs2, rs1, 3'b101, rd);
			8: return enc_i(r[11:0], rs1, 3'b000, rd, op_imm);
			9: return enc_u(r[19:0], rd, op_lui);
			default: return enc_u(r[19:0], rd, op_auipc);
		endcase
	endfunction

	function automatic void push_redirect(input logic [31:0] target);
		redir_q.push_back(target);
		redir_test_q.push_back(test_name);
	endfunction

	// sequential ISA semantics on the model state
	function automatic void exec_model(input logic [31:0] ins, input logic [31:0] ipc);
		logic [6:0] opc;
		logic [2:0] f3;
		logic [4:0] rd;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_i;
		logic [31:0] imm_s;
		logic [31:0] imm_b;
		logic [31:0] imm_u;
		logic [31:0] imm_j;
		logic [31:0] res;
		logic writes;
		int idx;
		int w;
		opc = ins[6:0];
		f3 = ins[14:12];
		rd = ins[11:7];
		a = ref_regs[ins[19:15]];
		b = ref_regs[ins[24:20]];
		imm_i = {{20{ins[31]}}, ins[31:20]};
		imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
		imm_u = {ins[31:12], 12'h000};
		imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
		res = '0;
		writes = 1'b1;
		case (opc)
			op_reg: begin
				case (f3)
					3'b000: res = ins[30] ? a - b : a + b;
					3'b001: res = a << b[4:0];
					3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					3'b100: res = a ^ b;
					3'b101: res = a >> b[4:0];
					3'b110: res = a | b;
					default: res = a & b;
				endcase
			end
			op_imm: res = a + imm_i;
			op_lui: res = imm_u;
			op_auipc: res = ipc + imm_u;
			op_load: begin
				idx = (a + imm_i) % dmem_bytes; // memory wraps
				w = idx - idx % 4;
				case (f3)
					3'b010: res = {ref_mem[w + 3], ref_mem[w + 2], ref_mem[w + 1], ref_mem[w]};
					3'b000: res = {{24{ref_mem[idx][7]}}, ref_mem[idx]};
					default: res = {24'h0, ref_mem[idx]};
				endcase
			end
			op_store: begin
				writes = 1'b0;
				idx = (a + imm_s) % dmem_bytes;
				w = idx - idx % 4;
				if (f3 == 3'b010) begin
					for (int k = 0; k < 4; k++) begin
						ref_mem[w + k] = b[8*k +: 8];
					end
				end else begin
					ref_mem[idx] = b[7:0];
				end
			end
			op_branch: begin
				writes = 1'b0;
				if ((f3 == 3'b000 && a == b) || (f3 == 3'b001 && a != b)) begin
					push_redirect(ipc + imm_b);
				end
			end
			op_jal: begin
				push_redirect(ipc + imm_j);
				res = ipc + 32'd4;
			end
			op_jalr: begin
				push_redirect((a + imm_i) & 32'hffff_fffe);
				res = ipc + 32'd4;
			end
			default: writes = 1'b0;
		endcase
		if (writes && rd != 5'd0) begin
			ref_regs[rd] = res;
			wb_rd_q.push_back(rd);
			wb_data_q.push_back(res);
			wb_test_q.push_back(test_name);
		end
	endfunction

	task automatic issue(input logic [31:0] ins);
		@(negedge clk);
		instr_valid = 1'b1;
		instr = ins;
		pc = pc_cur;
		exec_model(ins, pc_cur);
		pc_cur = pc_cur + 32'd4; // fetch never follows redirects
		issued++;
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			instr_valid = 1'b0;
		end
	endtask

	task automatic check_drained();
		if (wb_rd_q.size() != 0 || redir_q.size() != 0) begin
			$display("ERROR: %s left %0d writebacks and %0d redirects never reported",
				test_name, wb_rd_q.size(), redir_q.size());
			other_errors++;
		end
		wb_rd_q.delete();
		wb_data_q.delete();
		wb_test_q.delete();
		redir_q.delete();
		redir_test_q.delete();
	endtask

	task automatic apply_reset();
		@(negedge clk);
		reset = 1'b1;
		instr_valid = 1'b0;
		check_drained();
		for (int i = 0; i < 32; i++) begin
			ref_regs[i] = '0;
		end
		for (int i = 0; i < dmem_bytes; i++) begin
			ref_mem[i] = '0;
		end
		repeat (16) begin
			@(negedge clk);
			if (wb_valid || redirect) begin
				$display("ERROR: %s output strobe high during reset", test_name);
				other_errors++;
			end
		end
		reset = 1'b0;
	endtask

	task automatic run_arith();
		logic [31:0] v;
		test_name = "arith";
		for (int r = 1; r < 32; r++) begin
			v = lcg_next();
			issue(enc_u(v[31:12], 5'(r), op_lui));
			issue(enc_i(v[11:0], 5'(r), 3'b000, 5'(r), op_imm));
		end
		for (int i = 0; i < n_alu; i++) begin
			issue(random_alu_instr(rand_reg(), rand_reg(), rand_reg(), 1'b0));
		end
		idle(4);
	endtask

	task automatic run_forwarding();
		logic [4:0] p1;
		logic [4:0] p2;
		logic [4:0] rd;
		test_name = "forwarding";
		for (int c = 0; c < n_chains; c++) begin
			p2 = rand_reg_nz();
			p1 = rand_reg_nz();
			for (int k = 0; k < chain_len; k++) begin
				rd = rand_reg_nz();
				issue(random_alu_instr(rd, p1, p2, 1'b1)); // reads the last two results
				p2 = p1;
				p1 = rd;
			end
		end
		idle(4);
	endtask

	task automatic run_mem();
		logic [31:0] r;
		logic [4:0] dst;
		logic [11:0] lane;
		test_name = "load_store";
		for (int i = 0; i < n_mem; i++) begin
			r = lcg_next();
			dst = rand_reg_nz();
			lane = {10'h0, r[17:16]};
			issue(enc_i({4'h0, r[7:2], 2'b00}, 5'd0, 3'b000, 5'd11, op_imm)); // word base
			if (r[20])
				issue(enc_s(12'h000, rand_reg_nz(), 5'd11, 3'b010));
			else
				issue(enc_s(lane, rand_reg_nz(), 5'd11, 3'b000));
			case (r[22:21])
				2'd0: issue(enc_i(12'h000, 5'd11, 3'b010, dst, op_load));
				2'd1, 2'd3: issue(enc_i(lane, 5'd11, 3'b000, dst, op_load));
				default: issue(enc_i(lane, 5'd11, 3'b100, dst, op_load));
			endcase
			issue(enc_r(7'h00, rand_reg(), dst, 3'b000, rand_reg_nz())); // uses the load
		end
		idle(4);
	endtask

	task automatic run_branches();
		logic [31:0] r;
		test_name = "branch";
		for (int i = 0; i < n_br; i++) begin
			r = lcg_next();
			issue(enc_i(r[11:0], 5'd0, 3'b000, 5'd12, op_imm));
			issue(enc_i(r[31] ? r[11:0] : r[11:0] + 12'd1, 5'd0, 3'b000, 5'd13, op_imm));
			issue(enc_b({r[27:16], 1'b0}, 5'd13, 5'd12, r[30] ? 3'b001 : 3'b000));
		end
		idle(4);
	endtask

	task automatic run_jumps();
		logic [31:0] r;
		logic [4:0] rd;
		test_name = "jump";
		for (int i = 0; i < n_jmp; i++) begin
			r = lcg_next();
			rd = (i % 4 == 0) ? 5'd0 : rand_reg_nz(); // some links to x0
			if (r[0])
				issue(enc_j({r[31:12], 1'b0}, rd));
			else
				issue(enc_i(r[31:20], rand_reg_nz(), 3'b000, rd, op_jalr));
		end
		idle(4);
	endtask

	task automatic run_reset();
		logic [31:0] r;
		test_name = "reset_mid_run";
		apply_reset();
		for (int i = 0; i < n_post / 2; i++) begin
			r = lcg_next();
			issue(enc_r(r[20] ? 7'h20 : 7'h00, rand_reg_nz(), rand_reg_nz(),
				r[21] ? 3'b110 : 3'b000, rand_reg_nz()));
		end
		for (int i = 0; i < n_post / 2; i++) begin
			r = lcg_next();
			issue(enc_i({4'h0, r[7:2], 2'b00}, 5'd0, r[20] ? 3'b100 : 3'b010,
				rand_reg_nz(), op_load));
		end
		idle(4);
	endtask

	// compare against the model at the falling edge, outputs settled
	always @(negedge clk) begin
		if (!reset) begin
			if (wb_valid) begin
				if (wb_rd_q.size() == 0) begin
					$display("ERROR: %s unexpected writeback x%0d = %08h", test_name, wb_rd, wb_data);
					other_errors++;
				end else begin
					if (wb_rd !== wb_rd_q[0] || wb_data !== wb_data_q[0]) begin
						$display("MISMATCH %s writeback: expected x%0d = %08h, actual x%0d = %08h",
							wb_test_q[0], wb_rd_q[0], wb_data_q[0], wb_rd, wb_data);
						mismatches++;
					end
					void'(wb_rd_q.pop_front());
					void'(wb_data_q.pop_front());
					void'(wb_test_q.pop_front());
				end
			end
			if (redirect) begin
				if (redir_q.size() == 0) begin
					$display("ERROR: %s unexpected redirect to %08h", test_name, redirect_pc);
					other_errors++;
				end else begin
					if (redirect_pc !== redir_q[0]) begin
						$display("MISMATCH %s redirect: expected %08h, actual %08h",
							redir_test_q[0], redir_q[0], redirect_pc);
						mismatches++;
					end
					void'(redir_q.pop_front());
					void'(redir_test_q.pop_front());
				end
			end
		end
	end

	initial begin
		#(watchdog_ns);
		$display("ERROR: watchdog expired after %0d ns in %s", watchdog_ns, test_name);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		int total;
		apply_reset();
		run_arith();
		run_forwarding();
		run_mem();
		run_branches();
		run_jumps();
		run_reset();
		test_name = "end";
		check_drained();
		total = mismatches + other_errors + dut.chk.fail_count;
		$display("%0d instructions, %0d mismatches, %0d other errors, %0d assertion failures",
			issued, mismatches, other_errors, dut.chk.fail_count);
		if (total == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: rv_core_top.sv
`timescale 1ns/1ns

module rv_core_top #(
	parameter int DMEM_ADDR_BITS = 6
) (
	input  logic                                   clk_i,
	input  logic                                   reset_i,
	input  logic                                   instr_valid_i,
	input  logic [31:0]                            instr_i,
	input  logic [rv_exec_pkg::reg_data_width-1:0] pc_i,
	output logic                                   wb_valid_o,
	output logic [4:0]                             wb_rd_o,
	output logic [rv_exec_pkg::reg_data_width-1:0] wb_data_o,
	output logic                                   redirect_o,
	output logic [rv_exec_pkg::reg_data_width-1:0] redirect_pc_o
);

	logic [4:0] rf_ra1;
	logic [4:0] rf_ra2;
	logic [rv_exec_pkg::reg_data_width-1:0] rf_rd1;
	logic [rv_exec_pkg::reg_data_width-1:0] rf_rd2;
	logic ex_valid;
	rv_exec_pkg::alu_op_t ex_alu_op;
	rv_exec_pkg::lis_op_t ex_lis_op;
	rv_exec_pkg::br_op_t ex_br_op;
	rv_exec_pkg::data_origin_t ex_origin;
	logic [rv_exec_pkg::reg_data_width-1:0] ex_rs1;
	logic [rv_exec_pkg::reg_data_width-1:0] ex_rs2;
	logic [rv_exec_pkg::reg_data_width-1:0] ex_imm;
	logic [rv_exec_pkg::reg_data_width-1:0] ex_pc;
	logic [4:0] ex_rd;
	logic ex_we;
	logic [rv_exec_pkg::reg_data_width-1:0] ex_d; // also the forwarding path
	logic ex_taken;
	logic [rv_exec_pkg::reg_data_width-1:0] ex_target;
	logic [DMEM_ADDR_BITS-1:0] mem_addr;
	logic [31:0] mem_wdata;
	logic [31:0] mem_rdata;
	logic [3:0] mem_be;
	logic mem_we;

	rv_decode u_decode (
		.clk_i         (clk_i),
		.reset_i       (reset_i),
		.instr_valid_i (instr_valid_i),
		.instr_i       (instr_i),
		.pc_i          (pc_i),
		.rf_ra1_o      (rf_ra1),
		.rf_ra2_o      (rf_ra2),
		.rf_rd1_i      (rf_rd1),
		.rf_rd2_i      (rf_rd2),
		.fwd_data_i    (ex_d),
		.ex_valid_o    (ex_valid),
		.ex_alu_op_o   (ex_alu_op),
		.ex_lis_op_o   (ex_lis_op),
		.ex_br_op_o    (ex_br_op),
		.ex_origin_o   (ex_origin),
		.ex_rs1_o      (ex_rs1),
		.ex_rs2_o      (ex_rs2),
		.ex_imm_o      (ex_imm),
		.ex_pc_o       (ex_pc),
		.ex_rd_o       (ex_rd),
		.ex_we_o       (ex_we)
	);

	// written from the writeback register, read-through covers decode
	rv_regfile u_regfile (
		.clk_i   (clk_i),
		.reset_i (reset_i),
		.ra1_i   (rf_ra1),
		.ra2_i   (rf_ra2),
		.rd1_o   (rf_rd1),
		.rd2_o   (rf_rd2),
		.we_i    (wb_valid_o),
		.wa_i    (wb_rd_o),
		.wd_i    (wb_data_o)
	);

	rv_execution_unit #(
		.DMEM_ADDR_BITS (DMEM_ADDR_BITS)
	) u_exec (
		.valid_i     (ex_valid),
		.alu_op_i    (ex_alu_op),
		.lis_op_i    (ex_lis_op),
		.br_op_i     (ex_br_op),
		.origin_i    (ex_origin),
		.rs1_i       (ex_rs1),
		.rs2_i       (ex_rs2),
		.imm_i       (ex_imm),
		.pc_i        (ex_pc),
		.d_o         (ex_d),
		.taken_o     (ex_taken),
		.target_o    (ex_target),
		.mem_addr_o  (mem_addr),
		.mem_wdata_o (mem_wdata),
		.mem_be_o    (mem_be),
		.mem_we_o    (mem_we),
		.mem_rdata_i (mem_rdata)
	);

	rv_data_mem #(
		.DMEM_ADDR_BITS (DMEM_ADDR_BITS)
	) u_dmem (
		.clk_i   (clk_i),
		.reset_i (reset_i),
		.addr_i  (mem_addr),
		.wdata_i (mem_wdata),
		.be_i    (mem_be),
		.we_i    (mem_we),
		.rdata_o (mem_rdata)
	);

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			wb_valid_o <= 1'b0;
			redirect_o <= 1'b0;
		end else begin
			wb_valid_o <= ex_valid && ex_we; // ex_we is already clear for x0
			redirect_o <= ex_taken;
		end
	end

	always_ff @(posedge clk_i) begin
		wb_rd_o       <= ex_rd;
		wb_data_o     <= ex_d;
		redirect_pc_o <= ex_target;
	end

endmodule

// File: rv_data_mem.sv
`timescale 1ns/1ns

module rv_data_mem #(
	parameter int DMEM_ADDR_BITS = 6
) (
	input  logic                      clk_i,
	input  logic                      reset_i,
	input  logic [DMEM_ADDR_BITS-1:0] addr_i,
	input  logic [31:0]               wdata_i,
	input  logic [3:0]                be_i,
	input  logic                      we_i,
	output logic [31:0]               rdata_o
);

	localparam int mem_depth = 2 ** DMEM_ADDR_BITS;

	logic [31:0] mem [mem_depth];

	assign rdata_o = mem[addr_i]; // async read

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			for (int i = 0; i < mem_depth; i++) begin
				mem[i] <= '0;
			end
		end else if (we_i) begin
			for (int b = 0; b < 4; b++) begin
				if (be_i[b]) mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
			end
		end
	end

endmodule

// File: rv_decode.sv
`timescale 1ns/1ns

module rv_decode (
	input  logic                                   clk_i,
	input  logic                                   reset_i,
	input  logic                                   instr_valid_i,
	input  logic [31:0]                            instr_i,
	input  logic [rv_exec_pkg::reg_data_width-1:0] pc_i,
	output logic [4:0]                             rf_ra1_o,
	output logic [4:0]                             rf_ra2_o,
	input  logic [rv_exec_pkg::reg_data_width-1:0] rf_rd1_i,
	input  logic [rv_exec_pkg::reg_data_width-1:0] rf_rd2_i,
	input  logic [rv_exec_pkg::reg_data_width-1:0] fwd_data_i,
	output logic                                   ex_valid_o,
	output rv_exec_pkg::alu_op_t                   ex_alu_op_o,
	output rv_exec_pkg::lis_op_t                   ex_lis_op_o,
	output rv_exec_pkg::br_op_t                    ex_br_op_o,
	output rv_exec_pkg::data_origin_t              ex_origin_o,
	output logic [rv_exec_pkg::reg_data_width-1:0] ex_rs1_o,
	output logic [rv_exec_pkg::reg_data_width-1:0] ex_rs2_o,
	output logic [rv_exec_pkg::reg_data_width-1:0] ex_imm_o,
	output logic [rv_exec_pkg::reg_data_width-1:0] ex_pc_o,
	output logic [4:0]                             ex_rd_o,
	output logic                                   ex_we_o
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [4:0] rs1;
	logic [4:0] rs2;
	logic [4:0] rd;
	logic [31:0] imm_i_type;
	logic [31:0] imm_s_type;
	logic [31:0] imm_b_type;
	logic [31:0] imm_u_type;
	logic [31:0] imm_j_type;
	rv_exec_pkg::alu_op_t alu_op;
	rv_exec_pkg::lis_op_t lis_op;
	rv_exec_pkg::br_op_t br_op;
	rv_exec_pkg::data_origin_t origin;
	logic [31:0] imm;
	logic we;
	logic [rv_exec_pkg::reg_data_width-1:0] op1;
	logic [rv_exec_pkg::reg_data_width-1:0] op2;

	assign opcode = instr_i[6:0];
	assign funct3 = instr_i[14:12];
	assign rs1    = instr_i[19:15];
	assign rs2    = instr_i[24:20];
	assign rd     = instr_i[11:7];

	assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
	assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
	assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
		instr_i[11:8], 1'b0};
	assign imm_u_type = {instr_i[31:12], 12'b0};
	assign imm_j_type = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
		instr_i[30:21], 1'b0};

	always_comb begin
		alu_op = rv_exec_pkg::alu_add;
		lis_op = rv_exec_pkg::lis_none;
		br_op  = rv_exec_pkg::br_none;
		origin = rv_exec_pkg::origin_rs2imm_rs1;
		imm    = imm_i_type;
		we     = 1'b0; // unknown opcodes fall through as no-ops
		case (opcode)
			rv_exec_pkg::opc_op: begin
				origin = rv_exec_pkg::origin_regs;
				we = 1'b1;
				case (funct3)
					3'b000: alu_op = instr_i[30] ? rv_exec_pkg::alu_sub : rv_exec_pkg::alu_add;
					3'b001: alu_op = rv_exec_pkg::alu_sll;
					3'b010: alu_op = rv_exec_pkg::alu_slt;
					3'b100: alu_op = rv_exec_pkg::alu_xor;
					3'b101: alu_op = rv_exec_pkg::alu_srl;
					3'b110: alu_op = rv_exec_pkg::alu_or;
					3'b111: alu_op = rv_exec_pkg::alu_and;
					default: we = 1'b0; // sltu not implemented
				endcase
			end
			rv_exec_pkg::opc_op_imm: we = (funct3 == 3'b000); // addi only
			rv_exec_pkg::opc_lui: begin
				alu_op = rv_exec_pkg::alu_pass_b;
				imm = imm_u_type;
				we = 1'b1;
			end
			rv_exec_pkg::opc_auipc: begin
				origin = rv_exec_pkg::origin_rs2imm_rs1pc;
				imm = imm_u_type;
				we = 1'b1;
			end
			rv_exec_pkg::opc_load: begin
				we = 1'b1;
				case (funct3)
					3'b000: lis_op = rv_exec_pkg::lis_lb;
					3'b010: lis_op = rv_exec_pkg::lis_lw;
					3'b100: lis_op = rv_exec_pkg::lis_lbu;
					default: we = 1'b0;
				endcase
			end
			rv_exec_pkg::opc_store: begin
				imm = imm_s_type;
				if (funct3 == 3'b000) lis_op = rv_exec_pkg::lis_sb;
				else if (funct3 == 3'b010) lis_op = rv_exec_pkg::lis_sw;
			end
			rv_exec_pkg::opc_branch: begin
				alu_op = rv_exec_pkg::alu_sub; // compare through zero flag
				origin = rv_exec_pkg::origin_regs; // conditional
				imm = imm_b_type;
				if (funct3 == 3'b000) br_op = rv_exec_pkg::br_beq;
				else if (funct3 == 3'b001) br_op = rv_exec_pkg::br_bne;
			end
			rv_exec_pkg::opc_jal: begin
				br_op = rv_exec_pkg::br_jump;
				origin = rv_exec_pkg::origin_rs2imm_rs1pc;
				imm = imm_j_type;
				we = 1'b1;
			end
			rv_exec_pkg::opc_jalr: begin
				br_op = rv_exec_pkg::br_jump; // absolute
				we = 1'b1;
			end
			default: ;
		endcase
		we = we && (rd != 5'd0);
	end

	// forward from the instruction now in execute
	assign rf_ra1_o = rs1;
	assign rf_ra2_o = rs2;
	assign op1 = (ex_we_o && ex_rd_o == rs1) ? fwd_data_i : rf_rd1_i;
	assign op2 = (ex_we_o && ex_rd_o == rs2) ? fwd_data_i : rf_rd2_i;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			ex_valid_o <= 1'b0;
			ex_we_o    <= 1'b0;
		end else begin
			ex_valid_o <= instr_valid_i;
			ex_we_o    <= instr_valid_i && we;
		end
	end

	always_ff @(posedge clk_i) begin
		if (instr_valid_i) begin
			ex_alu_op_o <= alu_op;
			ex_lis_op_o <= lis_op;
			ex_br_op_o  <= br_op;
			ex_origin_o <= origin;
			ex_rs1_o    <= op1;
			ex_rs2_o    <= op2;
			ex_imm_o    <= imm;
			ex_pc_o     <= pc_i;
			ex_rd_o     <= rd;
		end
	end

endmodule

// File: rv_exec_pkg.sv
package rv_exec_pkg;

	localparam int reg_data_width = 32;

	// alu operations
	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt,
		alu_sll,
		alu_srl,
		alu_pass_b // lui
	} alu_op_t;

	typedef enum logic [2:0] {
		lis_none,
		lis_lw,
		lis_lb,
		lis_lbu,
		lis_sw,
		lis_sb
	} lis_op_t;

	typedef enum logic [1:0] {
		br_none,
		br_beq,
		br_bne,
		br_jump
	} br_op_t;

	// where the alu operands come from
	typedef enum logic [1:0] {
		origin_regs,
		origin_rs2imm_rs1,
		origin_rs2imm_rs1pc
	} data_origin_t;

	// rv32i major opcodes
	localparam logic [6:0] opc_op     = 7'b0110011;
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_load   = 7'b0000011;
	localparam logic [6:0] opc_store  = 7'b0100011;
	localparam logic [6:0] opc_branch = 7'b1100011;
	localparam logic [6:0] opc_jal    = 7'b1101111;
	localparam logic [6:0] opc_jalr   = 7'b1100111;
	localparam logic [6:0] opc_lui    = 7'b0110111;
	localparam logic [6:0] opc_auipc  = 7'b0010111;

endpackage

// File: rv_execution_unit.sv
`timescale 1ns/1ns

module rv_execution_unit #(
	parameter int DMEM_ADDR_BITS = 6
) (
	input  logic                                   valid_i,
	input  rv_exec_pkg::alu_op_t                   alu_op_i,
	input  rv_exec_pkg::lis_op_t                   lis_op_i,
	input  rv_exec_pkg::br_op_t                    br_op_i,
	input  rv_exec_pkg::data_origin_t              origin_i,
	input  logic [rv_exec_pkg::reg_data_width-1:0] rs1_i,
	input  logic [rv_exec_pkg::reg_data_width-1:0] rs2_i,
	input  logic [rv_exec_pkg::reg_data_width-1:0] imm_i,
	input  logic [rv_exec_pkg::reg_data_width-1:0] pc_i,
	output logic [rv_exec_pkg::reg_data_width-1:0] d_o,
	output logic                                   taken_o,
	output logic [rv_exec_pkg::reg_data_width-1:0] target_o,
	output logic [DMEM_ADDR_BITS-1:0]              mem_addr_o,
	output logic [31:0]                            mem_wdata_o,
	output logic [3:0]                             mem_be_o,
	output logic                                   mem_we_o,
	input  logic [31:0]                            mem_rdata_i
);

	logic [rv_exec_pkg::reg_data_width-1:0] s1;
	logic [rv_exec_pkg::reg_data_width-1:0] s2;
	logic [rv_exec_pkg::reg_data_width-1:0] alu_d;
	logic [rv_exec_pkg::reg_data_width-1:0] load_d;
	logic [29:0] word_addr;
	logic zero;
	logic lis_we;
	logic br_taken;

	always_comb begin
		case (origin_i)
			rv_exec_pkg::origin_rs2imm_rs1: begin
				s1 = rs1_i;
				s2 = imm_i;
			end
			rv_exec_pkg::origin_rs2imm_rs1pc: begin
				s1 = pc_i;
				s2 = imm_i;
			end
			default: begin // regs
				s1 = rs1_i;
				s2 = rs2_i;
			end
		endcase
		// conditional branch always compares the two registers
		if (br_op_i == rv_exec_pkg::br_beq || br_op_i == rv_exec_pkg::br_bne) begin
			s1 = rs1_i;
			s2 = rs2_i;
		end
	end

	always_comb begin
		if (br_op_i == rv_exec_pkg::br_jump)
			d_o = pc_i + 32'd4; // link
		else if (lis_op_i inside {rv_exec_pkg::lis_lw, rv_exec_pkg::lis_lb, rv_exec_pkg::lis_lbu})
			d_o = load_d;
		else
			d_o = alu_d;
	end

	assign mem_addr_o = word_addr[DMEM_ADDR_BITS-1:0]; // wraps with the memory depth
	assign mem_we_o = valid_i && lis_we;
	assign taken_o = valid_i && br_taken;

	rv_alu u_alu (
		.alu_op_i (alu_op_i),
		.s1_i     (s1),
		.s2_i     (s2),
		.d_o      (alu_d),
		.zero_o   (zero)
	);

	rv_lis u_lis (
		.lis_op_i    (lis_op_i),
		.addr_i      (alu_d),
		.val_write_i (rs2_i),
		.mem_addr_o  (word_addr),
		.mem_wdata_o (mem_wdata_o),
		.mem_be_o    (mem_be_o),
		.mem_we_o    (lis_we),
		.mem_rdata_i (mem_rdata_i),
		.val_read_o  (load_d)
	);

	rv_br u_br (
		.br_op_i  (br_op_i),
		.origin_i (origin_i),
		.zero_i   (zero),
		.pc_i     (pc_i),
		.s1_i     (s1),
		.s2_i     (imm_i), // offset, not the compare operand
		.taken_o  (br_taken),
		.target_o (target_o)
	);

endmodule

// File: rv_lis.sv
`timescale 1ns/1ns

module rv_lis (
	input  rv_exec_pkg::lis_op_t                   lis_op_i,
	input  logic [rv_exec_pkg::reg_data_width-1:0] addr_i,
	input  logic [rv_exec_pkg::reg_data_width-1:0] val_write_i,
	output logic [29:0]                            mem_addr_o,
	output logic [31:0]                            mem_wdata_o,
	output logic [3:0]                             mem_be_o,
	output logic                                   mem_we_o,
	input  logic [31:0]                            mem_rdata_i,
	output logic [rv_exec_pkg::reg_data_width-1:0] val_read_o
);

	logic [1:0] lane;
	logic [7:0] rd_byte;

	assign mem_addr_o = addr_i[31:2]; // word index
	assign lane = addr_i[1:0];
	assign rd_byte = mem_rdata_i[8*lane +: 8];
	assign mem_we_o = (lis_op_i == rv_exec_pkg::lis_sw) || (lis_op_i == rv_exec_pkg::lis_sb);

	always_comb begin
		mem_wdata_o = val_write_i;
		mem_be_o = 4'b0000;
		case (lis_op_i)
			rv_exec_pkg::lis_sw: mem_be_o = 4'b1111;
			rv_exec_pkg::lis_sb: begin
				mem_wdata_o = {4{val_write_i[7:0]}}; // byte on every lane
				mem_be_o = 4'b0001 << lane;
			end
			default: ;
		endcase
	end

	always_comb begin
		case (lis_op_i)
			rv_exec_pkg::lis_lw:  val_read_o = mem_rdata_i;
			rv_exec_pkg::lis_lb:  val_read_o = {{24{rd_byte[7]}}, rd_byte};
			rv_exec_pkg::lis_lbu: val_read_o = {24'b0, rd_byte};
			default:              val_read_o = '0;
		endcase
	end

endmodule

// File: rv_regfile.sv
`timescale 1ns/1ns

module rv_regfile (
	input  logic                                   clk_i,
	input  logic                                   reset_i,
	input  logic [4:0]                             ra1_i,
	input  logic [4:0]                             ra2_i,
	output logic [rv_exec_pkg::reg_data_width-1:0] rd1_o,
	output logic [rv_exec_pkg::reg_data_width-1:0] rd2_o,
	input  logic                                   we_i,
	input  logic [4:0]                             wa_i,
	input  logic [rv_exec_pkg::reg_data_width-1:0] wd_i
);

	logic [rv_exec_pkg::reg_data_width-1:0] regs [1:31]; // no storage for x0

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i && wa_i != 5'd0) begin
			regs[wa_i] <= wd_i;
		end
	end

	// x0 reads zero, a write in flight passes straight through
	assign rd1_o = (ra1_i == 5'd0) ? '0 : (we_i && wa_i == ra1_i) ? wd_i : regs[ra1_i];
	assign rd2_o = (ra2_i == 5'd0) ? '0 : (we_i && wa_i == ra2_i) ? wd_i : regs[ra2_i];

endmodule
